// ==== rtl/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  // register and pc width
  localparam int xlen = 32;

  // pc advances one word per fetch
  localparam int insn_bytes = 4;

  // funct fields that select the supported ALU ops
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, rv32 encoding
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011
  } opcode_e;

  // operation class chosen in decode
  typedef enum logic [2:0] {
    alu_none = 3'd0,
    alu_lui  = 3'd1,
    alu_addi = 3'd2,
    alu_add  = 3'd3,
    alu_sub  = 3'd4
  } alu_op_e;

  // what occupies writeback in a given cycle
  typedef enum logic [3:0] {
    cycle_invalid  = 4'd0,
    cycle_reset    = 4'd1,
    cycle_no_stall = 4'd2
  } cycle_status_e;

  // state entering decode
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } fetch_t;

  // state entering execute
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    alu_op_e       alu_op;
    reg_idx_t      rd;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    logic          writes_rd;
    word_t         rs1_data;
    word_t         rs2_data;
    word_t         imm_i;
  } exec_t;

  // state entering memory, and again entering writeback
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    logic          writes_rd;
    reg_idx_t      rd;
    word_t         result;
  } mem_t;

  // register file write, also the writeback forwarding source
  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } rf_write_t;

  // writeback trace seen at the top level
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    logic          we;
    reg_idx_t      rd;
    word_t         data;
  } retire_t;

  // bubble contents held by every stage register while in reset
  localparam fetch_t fetch_reset = '{pc: '0, insn: '0, status: cycle_reset};

  localparam exec_t exec_reset = '{
    pc: '0,
    insn: '0,
    status: cycle_reset,
    alu_op: alu_none,
    rd: '0,
    rs1: '0,
    rs2: '0,
    writes_rd: 1'b0,
    rs1_data: '0,
    rs2_data: '0,
    imm_i: '0
  };

  localparam mem_t mem_reset = '{
    pc: '0,
    insn: '0,
    status: cycle_reset,
    writes_rd: 1'b0,
    rd: '0,
    result: '0
  };

endpackage

// ==== rtl/rv_fetch.sv ====
`timescale 1ns/1ns

module rv_fetch import rv_pipe_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  word_t  insn_i,
  output word_t  pc_o,
  output fetch_t fetch_o
);

  word_t  pc_q;
  fetch_t fetch_q;

  // pc moves on every cycle, there are no stalls or redirects
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_q + word_t'(insn_bytes);
    end
  end

  // insn_i is the word at pc_q, presented by the memory before this edge
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= fetch_reset;
    end else begin
      fetch_q <= '{pc: pc_q, insn: insn_i, status: cycle_no_stall};
    end
  end

  assign pc_o    = pc_q;
  assign fetch_o = fetch_q;

endmodule

// ==== rtl/rv_reg_file.sv ====
`timescale 1ns/1ns

module rv_reg_file import rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_idx_t  rs1_i,
  input  reg_idx_t  rs2_i,
  input  rf_write_t wr_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  // x0 has no storage, it is hardwired to zero on the read side
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we && wr_i.rd != '0) begin
      regs[wr_i.rd] <= wr_i.data;
    end
  end

  // write-through so a reader three behind its producer sees the new value
  function automatic word_t read_port(reg_idx_t idx);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wr_i.we && wr_i.rd == idx) begin
      val = wr_i.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  assign rs1_data_o = read_port(rs1_i);
  assign rs2_data_o = read_port(rs2_i);

endmodule

// ==== rtl/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode import rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  fetch_t    fetch_i,
  input  rf_write_t wr_i,
  output exec_t     exec_o
);

  // instruction fields, R-type split
  logic [6:0] funct7;
  reg_idx_t   rs2;
  reg_idx_t   rs1;
  logic [2:0] funct3;
  reg_idx_t   rd;
  opcode_e    opcode;
  word_t      imm_i;

  alu_op_e alu_op;
  logic    writes_rd;
  word_t   rs1_data;
  word_t   rs2_data;
  exec_t   exec_q;

  assign funct7 = fetch_i.insn[31:25];
  assign rs2    = fetch_i.insn[24:20];
  assign rs1    = fetch_i.insn[19:15];
  assign funct3 = fetch_i.insn[14:12];
  assign rd     = fetch_i.insn[11:7];
  assign opcode = opcode_e'(fetch_i.insn[6:0]);

  // I immediate, sign bit is insn[31]
  assign imm_i = {{(xlen-12){fetch_i.insn[31]}}, fetch_i.insn[31:20]};

  // anything not matched below falls through as a no-op
  always_comb begin
    alu_op = alu_none;
    case (opcode)
      op_lui: begin
        alu_op = alu_lui;
      end
      op_reg_imm: begin
        if (funct3 == funct3_add) begin
          alu_op = alu_addi;
        end
      end
      op_reg_reg: begin
        if (funct3 == funct3_add && funct7 == funct7_base) begin
          alu_op = alu_add;
        end else if (funct3 == funct3_add && funct7 == funct7_sub) begin
          alu_op = alu_sub;
        end
      end
      default: begin
        alu_op = alu_none;
      end
    endcase
  end

  // every supported op writes rd
  assign writes_rd = (alu_op != alu_none);

  rv_reg_file i_rv_reg_file (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .wr_i       (wr_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      exec_q <= exec_reset;
    end else begin
      exec_q <= '{
        pc: fetch_i.pc,
        insn: fetch_i.insn,
        status: fetch_i.status,
        alu_op: alu_op,
        rd: rd,
        rs1: rs1,
        rs2: rs2,
        writes_rd: writes_rd,
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm_i: imm_i
      };
    end
  end

  assign exec_o = exec_q;

endmodule

// ==== rtl/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute import rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  exec_t     exec_i,
  input  rf_write_t wb_i,
  output mem_t      mem_o
);

  mem_t  mem_q;
  word_t op_a;
  word_t op_b;
  word_t result;

  // operand select, memory stage wins over writeback
  // the register value is already write-through for distance three
  function automatic word_t fwd_sel(reg_idx_t idx, word_t reg_val);
    word_t val;
    if (mem_q.writes_rd && mem_q.rd != '0 && mem_q.rd == idx) begin
      // distance one, producer is one stage ahead
      val = mem_q.result;
    end else if (wb_i.we && wb_i.rd != '0 && wb_i.rd == idx) begin
      // distance two, producer sits in writeback
      val = wb_i.data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  assign op_a = fwd_sel(exec_i.rs1, exec_i.rs1_data);
  assign op_b = fwd_sel(exec_i.rs2, exec_i.rs2_data);

  // ALU
  always_comb begin
    case (exec_i.alu_op)
      alu_lui: begin
        // upper immediate, low 12 bits zero
        result = {exec_i.insn[31:12], 12'b0};
      end
      alu_addi: begin
        result = op_a + exec_i.imm_i;
      end
      alu_add: begin
        result = op_a + op_b;
      end
      alu_sub: begin
        result = op_a - op_b;
      end
      default: begin
        // no-op, result is never written
        result = '0;
      end
    endcase
  end

  // memory stage register, nothing happens in memory besides the hop
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q <= mem_reset;
    end else begin
      mem_q <= '{
        pc: exec_i.pc,
        insn: exec_i.insn,
        status: exec_i.status,
        writes_rd: exec_i.writes_rd,
        rd: exec_i.rd,
        result: result
      };
    end
  end

  assign mem_o = mem_q;

endmodule

// ==== rtl/rv_writeback.sv ====
`timescale 1ns/1ns

module rv_writeback import rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  mem_t      mem_i,
  output rf_write_t wr_o,
  output retire_t   retire_o
);

  mem_t wb_q;
  logic we;

  // writeback stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= mem_reset;
    end else begin
      wb_q <= mem_i;
    end
  end

  // x0 writes are dropped here, so downstream never sees rd 0 with we set
  assign we = wb_q.writes_rd && (wb_q.rd != '0);

  // register file write, also feeds execute forwarding
  assign wr_o = '{we: we, rd: wb_q.rd, data: wb_q.result};

  // trace of whatever sits in writeback this cycle
  assign retire_o = '{
    pc: wb_q.pc,
    insn: wb_q.insn,
    status: wb_q.status,
    we: we,
    rd: wb_q.rd,
    data: wb_q.result
  };

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_pipe_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  word_t   insn_i,
  output word_t   pc_o,
  output retire_t retire_o
);

  // stage to stage state
  fetch_t    fetch_w;
  exec_t     exec_w;
  mem_t      mem_w;
  // writeback result, into the register file and execute forwarding
  rf_write_t wr_w;

  rv_fetch i_rv_fetch (
    .clk     (clk),
    .rst     (rst),
    .insn_i  (insn_i),
    .pc_o    (pc_o),
    .fetch_o (fetch_w)
  );

  rv_decode i_rv_decode (
    .clk     (clk),
    .rst     (rst),
    .fetch_i (fetch_w),
    .wr_i    (wr_w),
    .exec_o  (exec_w)
  );

  rv_execute i_rv_execute (
    .clk    (clk),
    .rst    (rst),
    .exec_i (exec_w),
    .wb_i   (wr_w),
    .mem_o  (mem_w)
  );

  rv_writeback i_rv_writeback (
    .clk      (clk),
    .rst      (rst),
    .mem_i    (mem_w),
    .wr_o     (wr_w),
    .retire_o (retire_o)
  );

endmodule

// ==== tb/rv_core_checker.sv ====
`timescale 1ns/1ns

module rv_core_checker import rv_pipe_pkg::*; (
  input logic    clk,
  input logic    rst,
  input word_t   pc_i,
  input retire_t retire_i
);

  // assertion failures seen so far
  int fail_count = 0;

  // writeback only ever holds a reset bubble or a retiring instruction
  status_known: assert property (
    @(posedge clk) disable iff (rst) retire_i.status != cycle_invalid
  ) else begin
    fail_count++;
    $error("retire status is cycle_invalid");
  end

  // x0 writes are squashed before they reach the trace
  no_x0_write: assert property (
    @(posedge clk) disable iff (rst) retire_i.we |-> retire_i.rd != '0
  ) else begin
    fail_count++;
    $error("retire write enable set for x0");
  end

  // fetch address stays on a word boundary
  pc_aligned: assert property (
    @(posedge clk) disable iff (rst) pc_i[1:0] == 2'b00
  ) else begin
    fail_count++;
    $error("pc_o is not word aligned");
  end

endmodule

// attached to the top-level ports of every rv_core
bind rv_core rv_core_checker i_rv_core_checker (
  .clk      (clk),
  .rst      (rst),
  .pc_i     (pc_o),
  .retire_i (retire_o)
);

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb import rv_pipe_pkg::*; ();

  // program image depth, 6 address bits
  localparam int mem_words = 64;
  localparam int reset_cycles = 8;
  // retire slots still showing reset bubbles after release
  localparam int fill_cycles = 4;
  // trailing no-op cycles after the last program word
  localparam int drain_cycles = 4;

  // one expected retirement
  typedef struct packed {
    word_t pc;
    word_t insn;
    logic  we;
    word_t data;
  } expect_t;

  logic    clk;
  logic    rst;
  word_t   insn;
  word_t   pc;
  retire_t retire;

  // flag nibble, insn word, expected result
  logic [67:0] testdata [0:mem_words-1];
  expect_t     expect_q [$];

  int n_insn;
  int fetch_count;
  int check_count;
  int err_count;
  int limit_cycles;
  int cycle_count = 0;

  rv_core i_rv_core (
    .clk      (clk),
    .rst      (rst),
    .insn_i   (insn),
    .pc_o     (pc),
    .retire_o (retire)
  );

  initial begin
    clk = 1'b0;
  end

  // 8 ns period
  always #4 clk = ~clk;

  task automatic compare_value(input string name, input word_t want, input word_t got);
    check_count++;
    if (got !== want) begin
      err_count++;
      $display("error: time %0t %s expected %h got %h", $time, name, want, got);
    end
  endtask

  // plays instruction memory, word at pc_o/4, zero past the program
  task automatic drive_fetch();
    int          idx;
    logic [67:0] entry;
    expect_t     want;
    idx = int'(pc / word_t'(insn_bytes));
    if (idx < n_insn) begin
      insn = testdata[6'(idx)][63:32];
    end else begin
      insn = '0;
    end
    // k-th fetch must present pc 4k
    compare_value("pc_o", word_t'(fetch_count * insn_bytes), pc);
    if (fetch_count < n_insn) begin
      entry = testdata[6'(fetch_count)];
    end else begin
      entry = '0;
    end
    want.pc = word_t'(fetch_count * insn_bytes);
    want.insn = entry[63:32];
    want.we = entry[64];
    want.data = entry[31:0];
    expect_q.push_back(want);
    fetch_count++;
  endtask

  // retire_o is stable here, half a cycle after the rising edge
  task automatic check_retire(input int cyc);
    expect_t want;
    if (cyc < fill_cycles) begin
      // pipeline still draining reset bubbles
      compare_value("retire_o.status", word_t'(cycle_reset), word_t'(retire.status));
      compare_value("retire_o.pc", '0, retire.pc);
      compare_value("retire_o.insn", '0, retire.insn);
      compare_value("retire_o.we", '0, word_t'(retire.we));
    end else begin
      want = expect_q.pop_front();
      compare_value("retire_o.status", word_t'(cycle_no_stall), word_t'(retire.status));
      compare_value("retire_o.pc", want.pc, retire.pc);
      compare_value("retire_o.insn", want.insn, retire.insn);
      compare_value("retire_o.we", word_t'(want.we), word_t'(retire.we));
      // rd and data only matter for a real write
      if (want.we) begin
        compare_value("retire_o.rd", word_t'(want.insn[11:7]), word_t'(retire.rd));
        compare_value("retire_o.data", want.data, retire.data);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    insn = '0;
    n_insn = 0;
    fetch_count = 0;
    check_count = 0;
    err_count = 0;
    // nibble f marks a word the file did not load
    for (int i = 0; i < mem_words; i++) begin
      testdata[6'(i)] = {4'hf, word_t'(i), ~word_t'(i)};
    end
    $readmemh("tb/rv_core_testdata.hex", testdata);
    while (n_insn < mem_words && testdata[6'(n_insn)][67:64] != 4'hf) begin
      n_insn++;
    end
    if (n_insn == 0) begin
      err_count++;
      $display("error: the testdata file held no instructions");
    end
    limit_cycles = n_insn + 20;
    repeat (reset_cycles) @(posedge clk);
    // release on a falling edge together with the first fetch word
    @(negedge clk);
    rst = 1'b0;
    for (int cyc = 0; cyc < n_insn + fill_cycles + drain_cycles; cyc++) begin
      if (cyc > 0) begin
        @(negedge clk);
      end
      check_retire(cyc);
      drive_fetch();
    end
    // failures of the bound assertions
    err_count += i_rv_core.i_rv_core_checker.fail_count;
    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // bound on run length, program plus twenty cycles
  always @(posedge clk) begin
    if (!rst) begin
      cycle_count++;
      if (cycle_count >= limit_cycles) begin
        $display("error: time %0t run did not end within %0d cycles", $time, limit_cycles);
        err_count++;
        err_count += i_rv_core.i_rv_core_checker.fail_count;
        $display("checks %0d errors %0d", check_count, err_count);
        $display("FAIL: see errors above");
        $finish;
      end
    end
  end

endmodule

// ==== tb/rv_core_testdata.hex ====
// one line per instruction: write flag (1 digit), insn word (8), expected rd value (8)
// the value is only checked where the write flag is set
1123450B712345000
1FFFFF137FFFFF000
1FFF00193FFFFFFFF
17FF00213000007FF
180000293FFFFF800
1001083332468A000
1401103B3EDCBA000
10011841300000000
1005204B3FFFFFFFF
140100533EDCBB000
10640059300000064
10055859300000069
100B58633000000D2
140B606B300000069
1FF900713FFFFFFF9
10030079300000003
100F70833FFFFFFFC
100A788930000000D
10048099300000000
101088A3300000009
140F88AB30000000A
100100B1300000001
1016B0BB300000002
1016B8C3300000003
1016C0CB300000004
1417C8D3300000002
0032B001300000000
101600DB300000001
0007B4E1300000000
00160202300000000
0036B0EB300000000
101DE0F3300000000
141B00FB3FFFFFFFF
0ABCDE03700000000
1000000B300000000
1FFF08113FFFFFFFF

// ==== project.f ====
rtl/rv_pipe_pkg.sv
rtl/rv_fetch.sv
rtl/rv_reg_file.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv_core.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the rv_core testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=rv_core_sim

verilator --binary --timing --assert -f project.f --top-module rv_core_tb \
  -Mdir obj_dir -o "$bin"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# assertion errors must not stop the run before the testbench summary
./obj_dir/"$bin" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
  echo "testbench reported failure"
  exit 1
fi
exit 0
